/* hdl/decPkg.sv */
package decPkg;

	localparam int regWidth = 6;
	localparam int immWidth = 33;
	localparam int instrWidth = 32;
	localparam int cmdWidth = 8;

	// register selector codes, the 6'h2x/6'h3x range holds the specials
	localparam logic [5:0] grDLR = 6'h20;
	localparam logic [5:0] grPC = 6'h22;
	localparam logic [5:0] grGBR = 6'h23;
	localparam logic [5:0] grIMM = 6'h3E;
	localparam logic [5:0] grZZR = 6'h3F;

	localparam logic [5:0] ucmdINVOP = 6'h00;
	localparam logic [5:0] ucmdALU3 = 6'h01;
	localparam logic [5:0] ucmdMUL3 = 6'h02;
	localparam logic [5:0] ucmdALUCMP = 6'h03;
	localparam logic [5:0] ucmdMOV_RM = 6'h04;
	localparam logic [5:0] ucmdMOV_MR = 6'h05;
	localparam logic [5:0] ucmdLEA_MR = 6'h06;
	localparam logic [5:0] ucmdMOV_IR = 6'h07;
	localparam logic [5:0] ucmdSHAD3 = 6'h08;
	localparam logic [5:0] ucmdSHADQ3 = 6'h09;
	localparam logic [5:0] ucmdSHLD3 = 6'h0A;
	localparam logic [5:0] ucmdSHLDQ3 = 6'h0B;
	localparam logic [5:0] ucmdBRA = 6'h0C;
	localparam logic [5:0] ucmdBSR = 6'h0D;

	// sub-commands, meaning depends on the command family
	localparam logic [5:0] ucixALU_ADD = 6'h00;
	localparam logic [5:0] ucixALU_SUB = 6'h01;
	localparam logic [5:0] ucixALU_ADC = 6'h02;
	localparam logic [5:0] ucixALU_SBB = 6'h03;
	localparam logic [5:0] ucixALU_TST = 6'h04;
	localparam logic [5:0] ucixALU_TSTQ = 6'h05;
	localparam logic [5:0] ucixALU_AND = 6'h06;
	localparam logic [5:0] ucixALU_OR = 6'h07;
	localparam logic [5:0] ucixALU_XOR = 6'h08;
	localparam logic [5:0] ucixALU_CMPEQ = 6'h0C;
	localparam logic [5:0] ucixALU_CMPQEQ = 6'h0D;
	localparam logic [5:0] ucixALU_CMPHI = 6'h0E;
	localparam logic [5:0] ucixALU_CMPQHI = 6'h0F;
	localparam logic [5:0] ucixALU_CMPGT = 6'h10;
	localparam logic [5:0] ucixALU_CMPQGT = 6'h11;
	localparam logic [5:0] ucixMUL3_MUL3S = 6'h00;
	localparam logic [5:0] ucixMUL3_MULS = 6'h01;
	localparam logic [5:0] ucixMUL3_MULU = 6'h02;
	localparam logic [5:0] ucixLDI_LDIX = 6'h00;
	localparam logic [5:0] ucixLDI_LDISH16 = 6'h01;

	typedef enum logic [4:0] {
		fmidZ = 5'h00,
		fmidINV = 5'h01,
		fmidREGREG = 5'h02,
		fmidREGIMMREG = 5'h03,
		fmidIMM8REG = 5'h04,
		fmidIMM12Z = 5'h05,
		fmidIMM12N = 5'h06,
		fmidPCDISP8 = 5'h07,
		fmidLDREGDISPREG = 5'h08,
		fmidREGSTREGDISP = 5'h09
	} fmidT;

	localparam logic [3:0] itySB = 4'h0;
	localparam logic [3:0] itySW = 4'h1;
	localparam logic [3:0] ityUW = 4'h5;
	localparam logic [3:0] ityNB = 4'h8;
	localparam logic [3:0] ityNW = 4'h9;

	// bit 2 marks the unsigned loads
	localparam logic [2:0] btySB = 3'd0;
	localparam logic [2:0] btySW = 3'd1;
	localparam logic [2:0] btySL = 3'd2;
	localparam logic [2:0] btySQ = 3'd3;
	localparam logic [2:0] btyUB = 3'd4;
	localparam logic [2:0] btyUW = 3'd5;
	localparam logic [2:0] btyUL = 3'd6;

	localparam logic [1:0] ixcAL = 2'd0;
	localparam logic [1:0] ixcCT = 2'd1;
	localparam logic [1:0] ixcCF = 2'd2;

	typedef union packed {
		struct packed {
			logic [3:0] major;
			logic exQ;
			logic exN;
			logic exM;
			logic exI;
			logic [3:0] ro;
			logic [3:0] minor;
			logic [3:0] prefix;
			logic [3:0] group;
			logic [3:0] rn;
			logic [3:0] rm;
		} regView;
		struct packed {
			logic [15:0] hiHalf;
			logic [7:0] midByte;
			logic [7:0] loByte;
		} immView;
	} instrWordT;

endpackage

/* hdl/pipeSlot.sv */
module pipeSlot #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic rstN,
	input logic upValid,
	output logic upReady,
	input logic [dataWidth-1:0] upData,
	output logic downValid,
	input logic downReady,
	output logic [dataWidth-1:0] downData
);

	// slot can take a new item when empty or draining this cycle
	assign upReady = !downValid || downReady;

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN)
			downValid <= 1'b0;
		else if (upReady)
			downValid <= upValid;
	end

	always_ff @(posedge clock) begin
		if (upValid && upReady)
			downData <= upData;
	end

endmodule

/* hdl/opcodeDecoder.sv */
module opcodeDecoder (
	input decPkg::instrWordT word,
	output logic [5:0] nmid,
	output decPkg::fmidT fmid,
	output logic [3:0] ity,
	output logic [2:0] bty,
	output logic [1:0] ccty,
	output logic [5:0] ucmdIx
);

	always_comb begin
		nmid = decPkg::ucmdINVOP;
		fmid = decPkg::fmidINV;
		ity = decPkg::itySB;
		bty = decPkg::btySB;
		ccty = decPkg::ixcAL;
		ucmdIx = '0;

		case (word.regView.group)
			4'h0: begin
				case (word.regView.major)
					4'h1: begin
						fmid = decPkg::fmidREGREG;
						nmid = decPkg::ucmdALU3;
						case (word.regView.minor)
							4'h0: ucmdIx = decPkg::ucixALU_ADD;
							4'h1: ucmdIx = decPkg::ucixALU_SUB;
							4'h2: begin
								nmid = decPkg::ucmdMUL3;
								ucmdIx = decPkg::ucixMUL3_MUL3S;
							end
							4'h5: ucmdIx = decPkg::ucixALU_AND;
							4'h6: ucmdIx = decPkg::ucixALU_OR;
							4'h7: ucmdIx = decPkg::ucixALU_XOR;
							4'h9: begin
								// two-operand forms, op selected by the Ro field
								ity = decPkg::ityNB;
								case (word.regView.ro)
									4'h0: ucmdIx = decPkg::ucixALU_ADD;
									4'h1: ucmdIx = decPkg::ucixALU_SUB;
									4'h2: ucmdIx = decPkg::ucixALU_ADC;
									4'h3: ucmdIx = decPkg::ucixALU_SBB;
									4'h4: begin
										nmid = decPkg::ucmdALUCMP;
										ity = decPkg::itySB;
										ucmdIx = word.regView.exQ ? decPkg::ucixALU_TSTQ :
											decPkg::ucixALU_TST;
									end
									4'h5: ucmdIx = decPkg::ucixALU_AND;
									4'h6: ucmdIx = decPkg::ucixALU_OR;
									4'h7: ucmdIx = decPkg::ucixALU_XOR;
									4'hC: begin
										nmid = decPkg::ucmdALUCMP;
										ity = decPkg::itySB;
										ucmdIx = word.regView.exQ ? decPkg::ucixALU_CMPQEQ :
											decPkg::ucixALU_CMPEQ;
									end
									4'hD: begin
										nmid = decPkg::ucmdALUCMP;
										ity = decPkg::itySB;
										ucmdIx = word.regView.exQ ? decPkg::ucixALU_CMPQHI :
											decPkg::ucixALU_CMPHI;
									end
									4'hE: begin
										nmid = decPkg::ucmdALUCMP;
										ity = decPkg::itySB;
										ucmdIx = word.regView.exQ ? decPkg::ucixALU_CMPQGT :
											decPkg::ucixALU_CMPGT;
									end
									default: begin
										nmid = decPkg::ucmdINVOP;
										fmid = decPkg::fmidINV;
										ity = decPkg::itySB;
									end
								endcase
							end
							default: begin
								nmid = decPkg::ucmdINVOP;
								fmid = decPkg::fmidINV;
							end
						endcase
					end
					4'hC, 4'hD, 4'hE, 4'hF: begin
						// pc-relative branch, disp20
						nmid = (word.regView.major == 4'hD) ? decPkg::ucmdBSR : decPkg::ucmdBRA;
						fmid = decPkg::fmidPCDISP8;
						bty = decPkg::btySW;
						ity = decPkg::itySW;
						if (word.regView.major == 4'hE)
							ccty = decPkg::ixcCT;
						else if (word.regView.major == 4'hF)
							ccty = decPkg::ixcCF;
					end
					default: ;
				endcase
			end
			4'h1: begin
				ity = decPkg::itySW;
				case (word.regView.major)
					4'h0, 4'h1, 4'h2, 4'h3: begin
						// store, or LEA when Q is set
						nmid = word.regView.exQ ? decPkg::ucmdLEA_MR : decPkg::ucmdMOV_RM;
						fmid = word.regView.exQ ? decPkg::fmidLDREGDISPREG :
							decPkg::fmidREGSTREGDISP;
						bty = {1'b0, word.regView.major[1:0]};
					end
					4'h8, 4'h9, 4'hA: begin
						nmid = decPkg::ucmdMOV_MR;
						fmid = decPkg::fmidLDREGDISPREG;
						bty = {word.regView.exQ, word.regView.major[1:0]};
					end
					4'hB: begin
						nmid = decPkg::ucmdMOV_MR;
						fmid = decPkg::fmidLDREGDISPREG;
						bty = word.regView.exQ ? decPkg::btyUL : decPkg::btySQ;
					end
					default: ;
				endcase
			end
			4'h2: begin
				fmid = decPkg::fmidREGIMMREG;
				ity = decPkg::ityUW;
				nmid = decPkg::ucmdALU3;
				case (word.regView.major)
					4'h0: ucmdIx = decPkg::ucixALU_ADD;
					4'h1: begin
						ity = decPkg::ityNW;
						ucmdIx = decPkg::ucixALU_ADD;
					end
					4'h2: begin
						nmid = decPkg::ucmdMUL3;
						ucmdIx = decPkg::ucixMUL3_MUL3S;
					end
					4'h5: ucmdIx = decPkg::ucixALU_AND;
					4'h6: ucmdIx = decPkg::ucixALU_OR;
					4'h7: ucmdIx = decPkg::ucixALU_XOR;
					4'h8: nmid = word.regView.exQ ? decPkg::ucmdSHADQ3 : decPkg::ucmdSHAD3;
					4'h9: nmid = word.regView.exQ ? decPkg::ucmdSHLDQ3 : decPkg::ucmdSHLD3;
					default: begin
						nmid = decPkg::ucmdINVOP;
						fmid = decPkg::fmidINV;
						ity = decPkg::itySB;
					end
				endcase
			end
			4'h8: begin
				// sub-op sits in word bits 7..5
				fmid = decPkg::fmidIMM8REG;
				nmid = decPkg::ucmdMOV_IR;
				ity = decPkg::ityUW;
				ucmdIx = decPkg::ucixLDI_LDIX;
				case (word.regView.rn[3:1])
					3'd0: ;
					3'd1: ity = decPkg::ityNW;
					3'd2: begin
						nmid = decPkg::ucmdALU3;
						ity = decPkg::itySW;
						ucmdIx = decPkg::ucixALU_ADD;
					end
					3'd3: ucmdIx = decPkg::ucixLDI_LDISH16;
					default: begin
						nmid = decPkg::ucmdINVOP;
						fmid = decPkg::fmidINV;
						ity = decPkg::itySB;
						ucmdIx = '0;
					end
				endcase
			end
			4'hA, 4'hB: begin
				nmid = decPkg::ucmdMOV_IR;
				fmid = word.regView.group[0] ? decPkg::fmidIMM12N : decPkg::fmidIMM12Z;
				ucmdIx = decPkg::ucixLDI_LDIX;
			end
			default: ;
		endcase

		// not an F-block word at all
		if (word.regView.prefix != 4'hF) begin
			nmid = decPkg::ucmdINVOP;
			fmid = decPkg::fmidZ;
			ity = decPkg::itySB;
			bty = decPkg::btySB;
			ccty = decPkg::ixcAL;
			ucmdIx = '0;
		end
	end

endmodule

/* hdl/operandMapper.sv */
module operandMapper (
	input decPkg::instrWordT word,
	input decPkg::fmidT fmid,
	input logic [3:0] ity,
	input logic [2:0] bty,
	input logic [1:0] ccty,
	input logic [5:0] ucmdIx,
	input logic [5:0] nmid,
	output logic [5:0] regN,
	output logic [5:0] regM,
	output logic [5:0] regO,
	output logic [7:0] uCmd,
	output logic [7:0] uIxt
);

	logic [5:0] rnDfl;
	logic [5:0] rmDfl;
	logic [5:0] roDfl;
	logic [5:0] immRegDfl;
	logic rnIsBase;
	logic rmIsBase;

	// R0, R1 and R15 live in the special register space
	function automatic logic isSpecial(input logic [3:0] nibble);
		return (nibble[3:1] == 3'b000) || (nibble == 4'hF);
	endfunction

	assign rnDfl = {isSpecial(word.regView.rn), word.regView.exN, word.regView.rn};
	assign rmDfl = {isSpecial(word.regView.rm), word.regView.exM, word.regView.rm};
	assign roDfl = {isSpecial(word.regView.ro), word.regView.exI, word.regView.ro};
	assign immRegDfl = {isSpecial(word.regView.rm), word.regView.rn[0], word.regView.rm};
	assign rnIsBase = (rnDfl[4:1] == 4'b0000);
	assign rmIsBase = (rmDfl[4:1] == 4'b0000);

	always_comb begin
		regN = decPkg::grZZR;
		regM = decPkg::grZZR;
		regO = decPkg::grZZR;
		uCmd = {ccty, nmid};
		uIxt = '0;

		case (fmid)
			decPkg::fmidREGREG: begin
				regN = rnDfl;
				regM = (ity == decPkg::ityNB) ? rnDfl : rmDfl;
				regO = (ity == decPkg::ityNB) ? rmDfl : roDfl;
				uIxt = {ccty, ucmdIx};
			end
			decPkg::fmidREGIMMREG: begin
				regN = rnDfl;
				regM = rmDfl;
				regO = decPkg::grIMM;
				uIxt = {ccty, ucmdIx};
			end
			decPkg::fmidIMM8REG: begin
				regN = immRegDfl;
				regM = decPkg::grIMM;
				regO = immRegDfl;
				uIxt = {ccty, ucmdIx};
			end
			decPkg::fmidIMM12Z, decPkg::fmidIMM12N: begin
				regN = decPkg::grDLR;
				regM = decPkg::grIMM;
				uIxt = {ccty, ucmdIx};
			end
			decPkg::fmidPCDISP8: begin
				regN = decPkg::grDLR;
				regM = decPkg::grPC;
				regO = decPkg::grIMM;
				uIxt = {ccty, bty[1:0], 1'b1, bty};
			end
			decPkg::fmidLDREGDISPREG: begin
				regN = rnDfl;
				regM = rmDfl;
				regO = decPkg::grIMM;
				uIxt = {ccty, bty[1:0], 1'b1, bty};
				if (rmIsBase) begin
					regM = rmDfl[0] ? decPkg::grGBR : decPkg::grPC;
					uIxt = {ccty, bty[1:0], 1'b1, bty[2], 2'b00};
				end
			end
			decPkg::fmidREGSTREGDISP: begin
				// source in Rm, base in Rn
				regN = rmDfl;
				regM = rnDfl;
				regO = decPkg::grIMM;
				uIxt = {ccty, bty[1:0], 1'b0, bty};
				if (rnIsBase) begin
					regM = rnDfl[0] ? decPkg::grGBR : decPkg::grPC;
					uIxt = {ccty, bty[1:0], 1'b0, bty[2], 2'b00};
				end
			end
			decPkg::fmidINV: uCmd = {ccty, decPkg::ucmdINVOP};
			default: ;
		endcase
	end

endmodule

/* hdl/immediateExtractor.sv */
module immediateExtractor (
	input decPkg::instrWordT word,
	input decPkg::fmidT fmid,
	input logic [3:0] ity,
	output logic [32:0] imm
);

	logic [15:0] hiHalf;
	logic [7:0] loByte;

	assign hiHalf = word.immView.hiHalf;
	assign loByte = word.immView.loByte;

	always_comb begin
		imm = '0;

		case (fmid)
			decPkg::fmidREGREG: imm = {28'b0, loByte[4:0]};
			decPkg::fmidREGIMMREG, decPkg::fmidLDREGDISPREG, decPkg::fmidREGSTREGDISP: begin
				// 9-bit field, ones above for the negative forms
				if (ity == decPkg::ityNW)
					imm = {{24{1'b1}}, hiHalf[8:0]};
				else
					imm = {24'b0, hiHalf[8:0]};
			end
			decPkg::fmidIMM8REG: begin
				case (ity)
					decPkg::itySW: imm = {{17{hiHalf[15]}}, hiHalf};
					decPkg::ityNW: imm = {{17{1'b1}}, hiHalf};
					default: imm = {17'b0, hiHalf};
				endcase
			end
			decPkg::fmidIMM12Z: imm = {9'b0, loByte, hiHalf};
			decPkg::fmidIMM12N: imm = {{9{1'b1}}, loByte, hiHalf};
			decPkg::fmidPCDISP8: begin
				// disp20 split over the low byte and bits 27..16
				imm = {{13{loByte[7]}}, loByte, hiHalf[11:0]};
			end
			default: ;
		endcase
	end

endmodule

/* hdl/instrDecoder.sv */
module instrDecoder (
	input logic clock,
	input logic rstN,
	input logic inValid,
	output logic inReady,
	input logic [decPkg::instrWidth-1:0] instrWord,
	output logic outValid,
	input logic outReady,
	output logic [decPkg::regWidth-1:0] regN,
	output logic [decPkg::regWidth-1:0] regM,
	output logic [decPkg::regWidth-1:0] regO,
	output logic [decPkg::immWidth-1:0] imm,
	output logic [decPkg::cmdWidth-1:0] uCmd,
	output logic [decPkg::cmdWidth-1:0] uIxt
);

	localparam int outWidth = 3 * decPkg::regWidth + decPkg::immWidth + 2 * decPkg::cmdWidth;

	logic midValid;
	logic midReady;
	decPkg::instrWordT midWord;

	logic [5:0] decNmid;
	decPkg::fmidT decFmid;
	logic [3:0] decIty;
	logic [2:0] decBty;
	logic [1:0] decCcty;
	logic [5:0] decUcmdIx;

	logic [decPkg::regWidth-1:0] mapRegN;
	logic [decPkg::regWidth-1:0] mapRegM;
	logic [decPkg::regWidth-1:0] mapRegO;
	logic [decPkg::cmdWidth-1:0] mapUCmd;
	logic [decPkg::cmdWidth-1:0] mapUIxt;
	logic [decPkg::immWidth-1:0] extImm;
	logic [outWidth-1:0] outData;

	pipeSlot #(.dataWidth(decPkg::instrWidth)) inSlot_i (
		.clock(clock), .rstN(rstN),
		.upValid(inValid), .upReady(inReady), .upData(instrWord),
		.downValid(midValid), .downReady(midReady), .downData(midWord)
	);

	opcodeDecoder opcodeDecoder_i (
		.word(midWord), .nmid(decNmid), .fmid(decFmid), .ity(decIty),
		.bty(decBty), .ccty(decCcty), .ucmdIx(decUcmdIx)
	);

	operandMapper operandMapper_i (
		.word(midWord), .fmid(decFmid), .ity(decIty), .bty(decBty),
		.ccty(decCcty), .ucmdIx(decUcmdIx), .nmid(decNmid),
		.regN(mapRegN), .regM(mapRegM), .regO(mapRegO),
		.uCmd(mapUCmd), .uIxt(mapUIxt)
	);

	immediateExtractor immediateExtractor_i (
		.word(midWord), .fmid(decFmid), .ity(decIty), .imm(extImm)
	);

	// decoded fields packed into one output register
	pipeSlot #(.dataWidth(outWidth)) outSlot_i (
		.clock(clock), .rstN(rstN),
		.upValid(midValid), .upReady(midReady),
		.upData({mapRegN, mapRegM, mapRegO, extImm, mapUCmd, mapUIxt}),
		.downValid(outValid), .downReady(outReady), .downData(outData)
	);

	assign {regN, regM, regO, imm, uCmd, uIxt} = outData;

endmodule

/* verification/instrDecoder_properties.sv */
module instrDecoderProperties (
	input logic clock,
	input logic rstN,
	input logic inReady,
	input logic outValid,
	input logic outReady,
	input logic [5:0] regN,
	input logic [5:0] regM,
	input logic [5:0] regO,
	input logic [32:0] imm,
	input logic [7:0] uCmd,
	input logic [7:0] uIxt
);
	timeunit 1ns;
	timeprecision 100ps;

	// both slots empty while reset is held
	property idleInReset;
		@(posedge clock) !rstN |-> !outValid && inReady;
	endproperty

	property idleAfterReset;
		@(posedge clock) $rose(rstN) |-> !outValid && inReady;
	endproperty

	property stableWhileStalled;
		@(posedge clock) disable iff (!rstN)
			outValid && !outReady |=> $stable({regN, regM, regO, imm, uCmd, uIxt});
	endproperty

	// a result waits until it is taken
	property validHeldUntilTaken;
		@(posedge clock) disable iff (!rstN)
			outValid && !outReady |=> outValid;
	endproperty

	assert property (idleInReset) else $error("outValid or inReady wrong during reset");
	assert property (idleAfterReset) else $error("outValid or inReady wrong after reset");
	assert property (stableWhileStalled) else $error("outputs changed while stalled");
	assert property (validHeldUntilTaken) else $error("outValid dropped before transfer");

endmodule

bind instrDecoder instrDecoderProperties instrDecoderProperties_i (
	.clock(clock), .rstN(rstN), .inReady(inReady), .outValid(outValid),
	.outReady(outReady), .regN(regN), .regM(regM), .regO(regO), .imm(imm),
	.uCmd(uCmd), .uIxt(uIxt)
);

/* verification/instrDecoderTb.sv */
module instrDecoderTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int randomCount = 300;
	localparam int directedCount = 23;

	logic clock;
	logic rstN;
	logic inValid;
	logic inReady;
	logic [31:0] instrWord;
	logic outValid;
	logic outReady;
	logic [5:0] regN;
	logic [5:0] regM;
	logic [5:0] regO;
	logic [32:0] imm;
	logic [7:0] uCmd;
	logic [7:0] uIxt;

	integer seed;
	logic [31:0] readyDraw;
	logic randomPhase;
	int errorCount;
	int checkedCount;
	int cycle;
	int limit;
	int accCycle;
	logic [66:0] expRes;
	logic [66:0] expQ[$];
	int accQ[$];
	logic [31:0] words[$];

	logic [31:0] directedWords[directedCount] = '{
		32'h1030F045, 32'h1031F0F1, 32'h1742F0AB, 32'h1005F067, 32'h1019F023,
		32'h18C9F023, 32'h1089F011, 32'h8012F130, 32'h0055F112, 32'hB8FFF1E7,
		32'h1123F2AB, 32'h9800F2C4, 32'hABCDF83F, 32'h8000F845, 32'h1234FA56,
		32'h9876FB80, 32'hC123F080, 32'hD7FFF001, 32'hE000F07F, 32'hF800F0FF,
		32'h12345678, 32'h0000F300, 32'h4000F100
	};

	instrDecoder instrDecoder_i (
		.clock(clock), .rstN(rstN), .inValid(inValid), .inReady(inReady),
		.instrWord(instrWord), .outValid(outValid), .outReady(outReady),
		.regN(regN), .regM(regM), .regO(regO), .imm(imm), .uCmd(uCmd), .uIxt(uIxt)
	);

	always #2 clock = ~clock;

	// R0, R1 and R15 map into the special bank
	function automatic logic inSpecialBank(input logic [3:0] nib);
		return (nib == 4'h0) || (nib == 4'h1) || (nib == 4'hF);
	endfunction

	function automatic logic [66:0] expectDecode(input logic [31:0] w);
		logic [5:0] dN;
		logic [5:0] dM;
		logic [5:0] dO;
		logic [5:0] dI;
		logic [5:0] rN;
		logic [5:0] rM;
		logic [5:0] rO;
		logic [32:0] im;
		logic [1:0] cc;
		logic [5:0] cmd;
		logic [5:0] sub;
		logic [7:0] xt;
		logic [2:0] sz;
		logic [3:0] baseNib;
		logic baseExt;
		logic store;
		logic ok;
		dN = {inSpecialBank(w[7:4]), w[26], w[7:4]};
		dM = {inSpecialBank(w[3:0]), w[25], w[3:0]};
		dO = {inSpecialBank(w[23:20]), w[24], w[23:20]};
		dI = {inSpecialBank(w[3:0]), w[4], w[3:0]};
		rN = decPkg::grZZR;
		rM = decPkg::grZZR;
		rO = decPkg::grZZR;
		im = '0;
		cc = decPkg::ixcAL;
		cmd = decPkg::ucmdINVOP;
		sub = '0;
		xt = '0;
		sz = '0;
		store = 1'b0;
		ok = 1'b0;
		if (w[15:12] == 4'hF) begin
			ok = 1'b1;
			case (w[11:8])
				4'h0: begin
					if (w[31:28] == 4'h1) begin
						rN = dN;
						rM = dM;
						rO = dO;
						im = {28'b0, w[4:0]};
						cmd = decPkg::ucmdALU3;
						case (w[19:16])
							4'h0: sub = decPkg::ucixALU_ADD;
							4'h1: sub = decPkg::ucixALU_SUB;
							4'h2: begin
								cmd = decPkg::ucmdMUL3;
								sub = decPkg::ucixMUL3_MUL3S;
							end
							4'h5: sub = decPkg::ucixALU_AND;
							4'h6: sub = decPkg::ucixALU_OR;
							4'h7: sub = decPkg::ucixALU_XOR;
							4'h9: begin
								case (w[23:20])
									4'h0: sub = decPkg::ucixALU_ADD;
									4'h1: sub = decPkg::ucixALU_SUB;
									4'h2: sub = decPkg::ucixALU_ADC;
									4'h3: sub = decPkg::ucixALU_SBB;
									4'h5: sub = decPkg::ucixALU_AND;
									4'h6: sub = decPkg::ucixALU_OR;
									4'h7: sub = decPkg::ucixALU_XOR;
									4'h4: sub = w[27] ? decPkg::ucixALU_TSTQ :
										decPkg::ucixALU_TST;
									4'hC: sub = w[27] ? decPkg::ucixALU_CMPQEQ :
										decPkg::ucixALU_CMPEQ;
									4'hD: sub = w[27] ? decPkg::ucixALU_CMPQHI :
										decPkg::ucixALU_CMPHI;
									4'hE: sub = w[27] ? decPkg::ucixALU_CMPQGT :
										decPkg::ucixALU_CMPGT;
									default: ok = 1'b0;
								endcase
								// compares keep the three defaults while the rest use Rn as source
								if (w[23:20] == 4'h4 || w[23:20] >= 4'hC) begin
									cmd = decPkg::ucmdALUCMP;
								end else begin
									rM = dN;
									rO = dM;
								end
							end
							default: ok = 1'b0;
						endcase
						xt = {cc, sub};
					end else if (w[31:30] == 2'b11) begin
						cmd = (w[31:28] == 4'hD) ? decPkg::ucmdBSR : decPkg::ucmdBRA;
						if (w[31:28] == 4'hE)
							cc = decPkg::ixcCT;
						else if (w[31:28] == 4'hF)
							cc = decPkg::ixcCF;
						rN = decPkg::grDLR;
						rM = decPkg::grPC;
						rO = decPkg::grIMM;
						im = {{13{w[7]}}, w[7:0], w[27:16]};
						xt = {cc, 2'b01, 1'b1, decPkg::btySW};
					end else begin
						ok = 1'b0;
					end
				end
				4'h1: begin
					case (w[31:28])
						4'h0, 4'h1, 4'h2, 4'h3: begin
							store = !w[27];
							cmd = w[27] ? decPkg::ucmdLEA_MR : decPkg::ucmdMOV_RM;
							sz = {1'b0, w[29:28]};
						end
						4'h8, 4'h9, 4'hA: begin
							cmd = decPkg::ucmdMOV_MR;
							sz = {w[27], w[29:28]};
						end
						4'hB: begin
							cmd = decPkg::ucmdMOV_MR;
							sz = w[27] ? decPkg::btyUL : decPkg::btySQ;
						end
						default: ok = 1'b0;
					endcase
					im = {24'b0, w[24:16]};
					rO = decPkg::grIMM;
					// stores take the data from Rm and the base from Rn
					rN = store ? dM : dN;
					rM = store ? dN : dM;
					baseNib = store ? w[7:4] : w[3:0];
					baseExt = store ? w[26] : w[25];
					xt = {cc, sz[1:0], !store, sz};
					if (!baseExt && baseNib[3:1] == 3'b000) begin
						rM = baseNib[0] ? decPkg::grGBR : decPkg::grPC;
						xt[1:0] = 2'b00;
					end
				end
				4'h2: begin
					rN = dN;
					rM = dM;
					rO = decPkg::grIMM;
					cmd = decPkg::ucmdALU3;
					im = {24'b0, w[24:16]};
					case (w[31:28])
						4'h0: sub = decPkg::ucixALU_ADD;
						4'h1: im = {{24{1'b1}}, w[24:16]};
						4'h2: begin
							cmd = decPkg::ucmdMUL3;
							sub = decPkg::ucixMUL3_MUL3S;
						end
						4'h5: sub = decPkg::ucixALU_AND;
						4'h6: sub = decPkg::ucixALU_OR;
						4'h7: sub = decPkg::ucixALU_XOR;
						4'h8: cmd = w[27] ? decPkg::ucmdSHADQ3 : decPkg::ucmdSHAD3;
						4'h9: cmd = w[27] ? decPkg::ucmdSHLDQ3 : decPkg::ucmdSHLD3;
						default: ok = 1'b0;
					endcase
					xt = {cc, sub};
				end
				4'h8: begin
					rN = dI;
					rM = decPkg::grIMM;
					rO = dI;
					cmd = decPkg::ucmdMOV_IR;
					sub = decPkg::ucixLDI_LDIX;
					im = {17'b0, w[31:16]};
					case (w[7:5])
						3'd0: ;
						3'd1: im = {{17{1'b1}}, w[31:16]};
						3'd2: begin
							cmd = decPkg::ucmdALU3;
							sub = decPkg::ucixALU_ADD;
							im = {{17{w[31]}}, w[31:16]};
						end
						3'd3: sub = decPkg::ucixLDI_LDISH16;
						default: ok = 1'b0;
					endcase
					xt = {cc, sub};
				end
				4'hA, 4'hB: begin
					rN = decPkg::grDLR;
					rM = decPkg::grIMM;
					cmd = decPkg::ucmdMOV_IR;
					sub = decPkg::ucixLDI_LDIX;
					im = {{9{w[8]}}, w[7:0], w[31:16]};
					xt = {cc, sub};
				end
				default: ok = 1'b0;
			endcase
		end
		if (!ok) begin
			rN = decPkg::grZZR;
			rM = decPkg::grZZR;
			rO = decPkg::grZZR;
			im = '0;
			cc = decPkg::ixcAL;
			cmd = decPkg::ucmdINVOP;
			xt = '0;
		end
		return {rN, rM, rO, im, cc, cmd, xt};
	endfunction

	function automatic logic [3:0] groupFromDraw(input logic [2:0] draw);
		case (draw)
			3'd0, 3'd1: return 4'h0;
			3'd2, 3'd3: return 4'h1;
			3'd4: return 4'h2;
			3'd5: return 4'h8;
			3'd6: return 4'hA;
			default: return 4'hB;
		endcase
	endfunction

	task automatic buildWords();
		logic [31:0] w;
		logic [31:0] pick;
		for (int i = 0; i < directedCount; i++)
			words.push_back(directedWords[i]);
		for (int i = 0; i < randomCount; i++) begin
			w = $random(seed);
			pick = $random(seed);
			w[15:12] = 4'hF;
			w[11:8] = groupFromDraw(pick[2:0]);
			if (w[11:8] == 4'h0) begin
				w[31:28] = pick[3] ? 4'h1 : {2'b11, pick[5:4]};
				if (pick[6])
					w[19:16] = 4'h9;
			end
			// about one word in eight leaves the F block
			if (pick[9:7] == 3'b000)
				w[15:12] = pick[13:10];
			words.push_back(w);
		end
	endtask

	task automatic sendWord(input logic [31:0] w);
		inValid = 1'b1;
		instrWord = w;
		do begin
			@(posedge clock);
		end while (!inReady);
		#1;
		inValid = 1'b0;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0)
			@(negedge clock);
		@(posedge clock);
		#1;
	endtask

	task automatic checkField(input string name, input logic [32:0] expVal,
		input logic [32:0] actVal);
		assert (actVal === expVal) else begin
			$display("MISMATCH at %0t ns: %s expected %h, actual %h",
				$time, name, expVal, actVal);
			errorCount++;
		end
	endtask

	// scoreboard and cycle limit on one clock edge
	always @(posedge clock) begin
		cycle++;
		if (rstN && outValid && outReady) begin
			assert (expQ.size() != 0) else begin
				$display("at %0t ns the DUT delivered a result with no word outstanding",
					$time);
				errorCount++;
			end
			if (expQ.size() != 0) begin
				expRes = expQ.pop_front();
				accCycle = accQ.pop_front();
				checkField("regN", expRes[66:61], regN);
				checkField("regM", expRes[60:55], regM);
				checkField("regO", expRes[54:49], regO);
				checkField("imm", expRes[48:16], imm);
				checkField("uCmd", expRes[15:8], uCmd);
				checkField("uIxt", expRes[7:0], uIxt);
				if (accCycle >= 0) begin
					assert (cycle == accCycle + 2) else begin
						$display("word accepted in cycle %0d came out in cycle %0d",
							accCycle, cycle);
						$display("latency is not 2 cycles");
						errorCount++;
					end
				end
				checkedCount++;
			end
		end
		if (rstN && inValid && inReady) begin
			expQ.push_back(expectDecode(instrWord));
			accQ.push_back(randomPhase ? -1 : cycle);
		end
		if (cycle > limit) begin
			$display("timeout after %0d cycles with %0d results still missing", cycle, expQ.size());
			errorCount++;
			$display("%0d words checked, %0d errors", checkedCount, errorCount);
			$display("Done: errors found");
			$finish;
		end
	end

	initial begin
		outReady = 1'b1;
		wait (randomPhase);
		forever begin
			@(posedge clock);
			#1;
			readyDraw = $random(seed);
			outReady = (readyDraw[1:0] != 2'b00);
		end
	end

	initial begin
		clock = 1'b0;
		rstN = 1'b1;
		inValid = 1'b0;
		instrWord = '0;
		randomPhase = 1'b0;
		errorCount = 0;
		checkedCount = 0;
		cycle = 0;
		seed = 32'h866c;
		buildWords();
		limit = words.size() * 6 + 100;
		#1 rstN = 1'b0;
		repeat (3) @(posedge clock);
		#1 rstN = 1'b1;
		@(posedge clock);
		#1;
		// directed words run without stalls so latency is checked too
		for (int i = 0; i < directedCount; i++)
			sendWord(words[i]);
		waitDrain();
		randomPhase = 1'b1;
		for (int i = directedCount; i < words.size(); i++) begin
			if (i % 7 == 3) begin
				@(posedge clock);
				#1;
			end
			sendWord(words[i]);
		end
		waitDrain();
		// every word has left, so a valid result here is a duplicate
		assert (!outValid) else begin
			$display("DUT still shows a valid result after every word was checked");
			errorCount++;
		end
		$display("%0d words checked, %0d errors", checkedCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* instrDecoder.f */
hdl/decPkg.sv
hdl/pipeSlot.sv
hdl/opcodeDecoder.sv
hdl/operandMapper.sv
hdl/immediateExtractor.sv
hdl/instrDecoder.sv
verification/instrDecoder_properties.sv
verification/instrDecoderTb.sv
